// ==== fv_bank_cfg.sv ====
// replay iteration, line count, node id and PE tag registers with iteration-change flag
`timescale 1ns/1ps
`include "fv_bank_macros.svh"

module fv_bank_cfg (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     load_stream,
    input  logic                     load_req,
    input  logic [`ITER_BITS-1:0]    replay_iter,
    input  logic [`FV_NUM_BITS-1:0]  fv_num,
    input  logic [`NODE_ID_BITS-1:0] req_node_id,
    input  logic [`PE_TAG_BITS-1:0]  req_pe_tag,
    output logic [`ITER_BITS-1:0]    iter,
    output logic                     iter_change,
    output logic [`LINE_BITS-1:0]    last_line,
    output logic [`NODE_ID_BITS-1:0] node_id,
    output logic [`PE_TAG_BITS-1:0]  pe_tag
);
    logic [`FV_NUM_BITS-1:0] fv_num_m1;
    logic [`LINE_BITS-1:0]   last_line_in;
    logic [`LINE_BITS-1:0]   last_line_q;
    logic                    load_any;

    // ceil(fv_num/2) - 1 equals (fv_num - 1) >> 1
    // valid for fv_num 1..16
    assign fv_num_m1    = fv_num - `FV_NUM_BITS'd1;
    assign last_line_in = fv_num_m1[`LINE_BITS:1];

    assign load_any = load_stream | load_req;

    // new iteration on the input while idle starts a stream
    assign iter_change = (replay_iter != iter);

    // bypass so the first read already sees the new count
    // matters for one-line frames
    assign last_line = load_any ? last_line_in : last_line_q;

    // latched iteration, cleared to 0
    always_ff @(posedge clk) begin
        if (reset) begin
            iter <= '0;
        end else if (load_stream) begin
            iter <= replay_iter;
        end
    end

    // line count for either service
    always_ff @(posedge clk) begin
        if (load_any) begin
            last_line_q <= last_line_in;
        end
    end

    // node id held for the whole read or write-back
    // request bus may change after acceptance
    always_ff @(posedge clk) begin
        if (load_req) begin
            node_id <= req_node_id;
            pe_tag  <= req_pe_tag;
        end
    end

endmodule

// ==== fv_bank_ctrl.sv ====
// top level of the feature-value bank controller: config regs, sequencer, output pipeline
`timescale 1ns/1ps
`include "fv_bank_macros.svh"

module fv_bank_ctrl (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [`ITER_BITS-1:0]        replay_iter,
    input  logic [`UPDATE_ITER_BITS-1:0] update_iter,
    input  logic                         stream_begin,
    input  logic [`FV_NUM_BITS-1:0]      fv_num,
    input  fv_bank_pkg::bank_req_t       req,
    input  logic [`FV_BANDWIDTH-1:0]     sram_rdata,
    output fv_bank_pkg::sram_req_t       sram_req,
    output fv_bank_pkg::small_fv_beat_t  small_beat,
    output fv_bank_pkg::edge_beat_t      edge_beat,
    output logic                         available
);
    logic                     load_stream;
    logic                     load_req;
    logic [`ITER_BITS-1:0]    iter;
    logic                     iter_change;
    logic [`LINE_BITS-1:0]    last_line;
    logic [`NODE_ID_BITS-1:0] node_id;
    logic [`PE_TAG_BITS-1:0]  pe_tag;
    fv_bank_pkg::rd_info_t    rd_tag;

    // latched frame settings
    fv_bank_cfg cfg_i (
        .clk         (clk),
        .reset       (reset),
        .load_stream (load_stream),
        .load_req    (load_req),
        .replay_iter (replay_iter),
        .fv_num      (fv_num),
        .req_node_id (req.node_id),
        .req_pe_tag  (req.pe_tag),
        .iter        (iter),
        .iter_change (iter_change),
        .last_line   (last_line),
        .node_id     (node_id),
        .pe_tag      (pe_tag)
    );

    // mode FSM and SRAM access
    fv_bank_seq seq_i (
        .clk          (clk),
        .reset        (reset),
        .update_iter  (update_iter),
        .stream_begin (stream_begin),
        .req          (req),
        .iter_change  (iter_change),
        .iter         (iter),
        .last_line    (last_line),
        .node_id      (node_id),
        .pe_tag       (pe_tag),
        .replay_iter  (replay_iter),
        .load_stream  (load_stream),
        .load_req     (load_req),
        .sram_req     (sram_req),
        .rd_tag       (rd_tag),
        .available    (available)
    );

    // read data to beats, two edges after the request
    fv_bank_out out_i (
        .clk        (clk),
        .reset      (reset),
        .rd_tag     (rd_tag),
        .sram_rdata (sram_rdata),
        .small_beat (small_beat),
        .edge_beat  (edge_beat)
    );

endmodule

// ==== fv_bank_macros.svh ====
// widths and counts of the feature-value bank and its address fields
`ifndef FV_BANK_MACROS_SVH
`define FV_BANK_MACROS_SVH

// one SRAM line holds two features
`define FV_BANDWIDTH        64
`define MAX_FV_NUM          16
`define LINE_BITS           3

// replay iterations and node slots streamed per iteration
`define MAX_REPLAY_ITER     4
`define ITER_BITS           2
`define NODE_PER_ITER_BANK  4
`define NODE_BITS           2

// node ids and edge PEs
`define MAX_NODE_ID         64
`define NODE_ID_BITS        6
`define NUM_EDGE_PE         4
`define PE_TAG_BITS         2

// iter + node slot + line, or node block + line
`define FV_MEM_ADDR_BITS    7
`define UPDATE_ITER_BITS    4

// feature count 0..16 needs one extra bit
`define FV_NUM_BITS         5

`endif

// ==== fv_bank_out.sv ====
// two-stage beat pipeline from SRAM read data to small-bank and edge-PE beats
`timescale 1ns/1ps
`include "fv_bank_macros.svh"

module fv_bank_out (
    input  logic                        clk,
    input  logic                        reset,
    input  fv_bank_pkg::rd_info_t       rd_tag,
    input  logic [`FV_BANDWIDTH-1:0]    sram_rdata,
    output fv_bank_pkg::small_fv_beat_t small_beat,
    output fv_bank_pkg::edge_beat_t     edge_beat
);
    // tag of the read whose data is on sram_rdata now
    fv_bank_pkg::rd_info_t tag_q;

    logic small_hit;
    logic edge_hit;

    assign small_hit = tag_q.to_small;
    assign edge_hit  = tag_q.to_edge;

    // stage 1
    // SRAM answers one cycle after the request
    always_ff @(posedge clk) begin
        if (reset) begin
            tag_q <= '0;
        end else begin
            tag_q <= rd_tag;
        end
    end

    // stage 2
    // strobes cleared on reset, data only loads on its own beats
    always_ff @(posedge clk) begin
        if (reset) begin
            small_beat.sos  <= 1'b0;
            small_beat.eos  <= 1'b0;
            edge_beat.valid <= 1'b0;
            edge_beat.sos   <= 1'b0;
            edge_beat.eos   <= 1'b0;
        end else begin
            small_beat.sos  <= small_hit & tag_q.sos;
            small_beat.eos  <= small_hit & tag_q.eos;
            edge_beat.valid <= edge_hit;
            edge_beat.sos   <= edge_hit & tag_q.sos;
            edge_beat.eos   <= edge_hit & tag_q.eos;
        end

        // small bank write address follows the stream slot and line
        if (small_hit) begin
            small_beat.a       <= tag_q.a;
            small_beat.fv_data <= sram_rdata;
        end

        // edge data keeps its PE tag
        if (edge_hit) begin
            edge_beat.pe_tag  <= tag_q.pe_tag;
            edge_beat.fv_data <= sram_rdata;
        end
    end

endmodule

// ==== fv_bank_pkg.sv ====
// bank types: address views and union, SRAM and request packets, output beats, read tag, states
`include "fv_bank_macros.svh"

package fv_bank_pkg;

    // stream view: iteration, node slot, line
    typedef struct packed {
        logic [`ITER_BITS-1:0] iter;
        logic [`NODE_BITS-1:0] node;
        logic [`LINE_BITS-1:0] line;
    } stream_addr_t;

    // node view: upper node id bits select an 8-line block
    typedef struct packed {
        logic [`NODE_ID_BITS-3:0] blk;
        logic [`LINE_BITS-1:0]    line;
    } node_addr_t;

    typedef union packed {
        stream_addr_t strm;
        node_addr_t   node;
    } fv_addr_u;

    // cen and wen active low
    typedef struct packed {
        logic                     cen;
        logic                     wen;
        fv_addr_u                 addr;
        logic [`FV_BANDWIDTH-1:0] wdata;
    } sram_req_t;

    // rd_wr high means write-back
    typedef struct packed {
        logic                     valid;
        logic                     rd_wr;
        logic                     wr_eos;
        logic [`NODE_ID_BITS-1:0] node_id;
        logic [`PE_TAG_BITS-1:0]  pe_tag;
        logic [`FV_BANDWIDTH-1:0] data;
    } bank_req_t;

    typedef struct packed {
        logic                           sos;
        logic                           eos;
        logic [`NODE_BITS+`LINE_BITS-1:0] a;
        logic [`FV_BANDWIDTH-1:0]       fv_data;
    } small_fv_beat_t;

    typedef struct packed {
        logic                     valid;
        logic                     sos;
        logic                     eos;
        logic [`PE_TAG_BITS-1:0]  pe_tag;
        logic [`FV_BANDWIDTH-1:0] fv_data;
    } edge_beat_t;

    // travels with each read until its data returns
    typedef struct packed {
        logic                           to_small;
        logic                           to_edge;
        logic                           sos;
        logic                           eos;
        logic [`NODE_BITS+`LINE_BITS-1:0] a;
        logic [`PE_TAG_BITS-1:0]        pe_tag;
    } rd_info_t;

    typedef enum logic [1:0] {
        idle       = 2'd0,
        stream     = 2'd1,
        write_back = 2'd2,
        edge_read  = 2'd3
    } bank_state_t;

endpackage

// ==== fv_bank_seq.sv ====
// mode FSM, line and node-slot counters, SRAM request and read tag generation
`timescale 1ns/1ps
`include "fv_bank_macros.svh"

module fv_bank_seq (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [`UPDATE_ITER_BITS-1:0] update_iter,
    input  logic                         stream_begin,
    input  fv_bank_pkg::bank_req_t       req,
    input  logic                         iter_change,
    input  logic [`ITER_BITS-1:0]        iter,
    input  logic [`LINE_BITS-1:0]        last_line,
    input  logic [`NODE_ID_BITS-1:0]     node_id,
    input  logic [`PE_TAG_BITS-1:0]      pe_tag,
    input  logic [`ITER_BITS-1:0]        replay_iter,
    output logic                         load_stream,
    output logic                         load_req,
    output fv_bank_pkg::sram_req_t       sram_req,
    output fv_bank_pkg::rd_info_t        rd_tag,
    output logic                         available
);
    fv_bank_pkg::bank_state_t state;
    fv_bank_pkg::bank_state_t state_nx;

    // counters point at the next access, both 0 in idle
    logic [`LINE_BITS-1:0] line_cnt;
    logic [`LINE_BITS-1:0] line_cnt_nx;
    logic [`NODE_BITS-1:0] node_cnt;
    logic [`NODE_BITS-1:0] node_cnt_nx;

    logic                      in_idle;
    logic                      req_go;
    logic                      stream_rd;
    logic                      edge_rd;
    logic                      wb_wr;
    logic                      last_line_hit;
    logic                      last_node_hit;
    logic [`ITER_BITS-1:0]     iter_sel;
    logic [`NODE_ID_BITS-1:0]  node_sel;
    logic [`PE_TAG_BITS-1:0]   pe_tag_sel;

    assign in_idle   = (state == fv_bank_pkg::idle);
    assign available = in_idle;

    // odd update iteration streams, even one serves requests
    assign load_stream = in_idle & update_iter[0] & (stream_begin | iter_change);
    assign req_go      = in_idle & ~update_iter[0] & req.valid;
    assign load_req    = req_go;

    assign stream_rd = load_stream | (state == fv_bank_pkg::stream);
    assign edge_rd   = (req_go & ~req.rd_wr) | (state == fv_bank_pkg::edge_read);
    assign wb_wr     = (req_go & req.rd_wr) | (state == fv_bank_pkg::write_back);

    assign last_line_hit = (line_cnt == last_line);
    assign last_node_hit = (node_cnt == `NODE_BITS'(`NODE_PER_ITER_BANK - 1));

    // first access takes fields straight off the inputs
    // later ones use the latched copies
    assign iter_sel   = in_idle ? replay_iter : iter;
    assign node_sel   = in_idle ? req.node_id : node_id;
    assign pe_tag_sel = in_idle ? req.pe_tag : pe_tag;

    always_comb begin
        state_nx     = state;
        line_cnt_nx  = line_cnt;
        node_cnt_nx  = node_cnt;
        sram_req     = '0;
        sram_req.cen = 1'b1;
        sram_req.wen = 1'b1;
        rd_tag       = '0;

        if (stream_rd) begin
            sram_req.cen            = 1'b0;
            sram_req.addr.strm.iter = iter_sel;
            sram_req.addr.strm.node = node_cnt;
            sram_req.addr.strm.line = line_cnt;
            rd_tag.to_small = 1'b1;
            rd_tag.sos      = in_idle;
            rd_tag.eos      = last_line_hit & last_node_hit;
            rd_tag.a        = {node_cnt, line_cnt};
            // contiguous walk, slot by slot
            if (last_line_hit) begin
                line_cnt_nx = '0;
                node_cnt_nx = node_cnt + 1'b1;
            end else begin
                line_cnt_nx = line_cnt + 1'b1;
            end
            if (last_line_hit && last_node_hit) begin
                state_nx    = fv_bank_pkg::idle;
                node_cnt_nx = '0;
            end else begin
                state_nx = fv_bank_pkg::stream;
            end
        end else if (edge_rd) begin
            sram_req.cen            = 1'b0;
            sram_req.addr.node.blk  = node_sel[`NODE_ID_BITS-1:2];
            sram_req.addr.node.line = line_cnt;
            rd_tag.to_edge = 1'b1;
            rd_tag.sos     = in_idle;
            rd_tag.eos     = last_line_hit;
            rd_tag.pe_tag  = pe_tag_sel;
            if (last_line_hit) begin
                state_nx    = fv_bank_pkg::idle;
                line_cnt_nx = '0;
            end else begin
                state_nx    = fv_bank_pkg::edge_read;
                line_cnt_nx = line_cnt + 1'b1;
            end
        end else if (wb_wr) begin
            // one beat per cycle, wr_eos closes the frame
            sram_req.cen            = 1'b0;
            sram_req.wen            = 1'b0;
            sram_req.addr.node.blk  = node_sel[`NODE_ID_BITS-1:2];
            sram_req.addr.node.line = line_cnt;
            sram_req.wdata          = req.data;
            if (req.wr_eos) begin
                state_nx    = fv_bank_pkg::idle;
                line_cnt_nx = '0;
            end else begin
                state_nx    = fv_bank_pkg::write_back;
                line_cnt_nx = line_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= fv_bank_pkg::idle;
            line_cnt <= '0;
            node_cnt <= '0;
        end else begin
            state    <= state_nx;
            line_cnt <= line_cnt_nx;
            node_cnt <= node_cnt_nx;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator, run from the project root

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_fv_bank_ctrl \
    --Mdir obj_dir -o sim_tb -f src.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
    exit 1
fi
exit 0

// ==== src.f ====
+incdir+.
fv_bank_pkg.sv
fv_bank_cfg.sv
fv_bank_seq.sv
fv_bank_out.sv
fv_bank_ctrl.sv
tb_clk_gen.sv
tb_fv_bank_ctrl.sv

// ==== tb_clk_gen.sv ====
// testbench clock and reset generator
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic reset
);
    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held for 3 rising edges, released mid-cycle
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// ==== tb_fv_bank_ctrl.sv ====
// testbench with SRAM model, reference function, stimulus, beat compare and reporting
`timescale 1ns/1ps
`include "fv_bank_macros.svh"

module tb_fv_bank_ctrl;
    logic                         clk;
    logic                         reset;
    logic [`ITER_BITS-1:0]        replay_iter;
    logic [`UPDATE_ITER_BITS-1:0] update_iter;
    logic                         stream_begin;
    logic [`FV_NUM_BITS-1:0]      fv_num;
    fv_bank_pkg::bank_req_t       req;
    logic [`FV_BANDWIDTH-1:0]     sram_rdata;
    fv_bank_pkg::sram_req_t       sram_req;
    fv_bank_pkg::small_fv_beat_t  small_beat;
    fv_bank_pkg::edge_beat_t      edge_beat;
    logic                         available;

    // SRAM model and the shadow copy behind expected data
    logic [`FV_BANDWIDTH-1:0]     mem [0:127];
    logic [`FV_BANDWIDTH-1:0]     ref_mem [0:127];
    logic [`FV_MEM_ADDR_BITS-1:0] sram_addr;

    // beats still owed by the DUT in order
    fv_bank_pkg::small_fv_beat_t exp_small_q [$];
    fv_bank_pkg::edge_beat_t     exp_edge_q [$];

    integer seed;
    int     cyc = 0;
    int     err_count = 0;
    int     test_count = 0;
    int     fail_tests = 0;
    int     small_frames = 0;
    int     edge_frames = 0;
    int     edge_sos_cyc = 0;
    int     req_cyc = 0;
    logic   small_open = 1'b0;

    tb_clk_gen clk_gen_i (
        .clk   (clk),
        .reset (reset)
    );

    fv_bank_ctrl dut_i (
        .clk          (clk),
        .reset        (reset),
        .replay_iter  (replay_iter),
        .update_iter  (update_iter),
        .stream_begin (stream_begin),
        .fv_num       (fv_num),
        .req          (req),
        .sram_rdata   (sram_rdata),
        .sram_req     (sram_req),
        .small_beat   (small_beat),
        .edge_beat    (edge_beat),
        .available    (available)
    );

    assign sram_addr = sram_req.addr;

    // synchronous SRAM with read data one cycle later
    always @(posedge clk) begin
        if (!sram_req.cen) begin
            if (!sram_req.wen) begin
                mem[sram_addr] <= sram_req.wdata;
            end else begin
                sram_rdata <= mem[sram_addr];
            end
        end
    end

    // rising edge count for latency checks
    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // reference content at an SRAM address
    function automatic logic [`FV_BANDWIDTH-1:0] expected_line(input logic [6:0] addr);
        return ref_mem[addr];
    endfunction

    // stream view of iteration, node slot and line
    function automatic logic [6:0] stream_addr(input logic [1:0] it, input int slot,
                                               input int line);
        return 7'(int'(it) * 32 + slot * 8 + line);
    endfunction

    // node view with an 8-line block per group of four node ids
    function automatic logic [6:0] node_addr(input logic [5:0] node, input int line);
        return 7'((int'(node) / 4) * 8 + line);
    endfunction

    task automatic report_mismatch(input string what, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("[FAIL] %0d ns: %s is %h, expected %h", $time, what, got, exp);
        err_count++;
    endtask

    // beat compare sampled mid-cycle where outputs are settled
    always @(negedge clk) begin
        fv_bank_pkg::small_fv_beat_t es;
        fv_bank_pkg::edge_beat_t     ee;
        if (!reset) begin
            // small bank has no valid so a frame runs sos to eos
            if (small_beat.sos || small_open) begin
                if (exp_small_q.size() == 0) begin
                    $display("unexpected small-bank beat at %0d ns", $time);
                    err_count++;
                end else begin
                    es = exp_small_q.pop_front();
                    // sos and eos, address, data
                    if (small_beat !== es) begin
                        $display("[FAIL] %0d ns: small beat %b%b/%0d/%h, expected %b%b/%0d/%h",
                                 $time, small_beat.sos, small_beat.eos, small_beat.a,
                                 small_beat.fv_data, es.sos, es.eos, es.a, es.fv_data);
                        err_count++;
                    end
                end
                small_open = !small_beat.eos;
                if (small_beat.eos) begin
                    small_frames++;
                end
            end
            if (edge_beat.valid) begin
                if (edge_beat.sos) begin
                    edge_sos_cyc = cyc;
                end
                if (exp_edge_q.size() == 0) begin
                    $display("unexpected edge-PE beat at %0d ns", $time);
                    err_count++;
                end else begin
                    ee = exp_edge_q.pop_front();
                    // sos and eos, PE tag, data
                    if (edge_beat !== ee) begin
                        $display("[FAIL] %0d ns: edge beat %b%b/%0d/%h, expected %b%b/%0d/%h",
                                 $time, edge_beat.sos, edge_beat.eos, edge_beat.pe_tag,
                                 edge_beat.fv_data, ee.sos, ee.eos, ee.pe_tag, ee.fv_data);
                        err_count++;
                    end
                end
                if (edge_beat.eos) begin
                    edge_frames++;
                end
            end
        end
    end

    // lines per node is fv rounded up to pairs
    task automatic queue_stream(input logic [1:0] it, input logic [4:0] fv);
        fv_bank_pkg::small_fv_beat_t b;
        int nl;
        nl = (int'(fv) + 1) / 2;
        for (int s = 0; s < `NODE_PER_ITER_BANK; s++) begin
            for (int l = 0; l < nl; l++) begin
                b.sos     = (s == 0 && l == 0);
                b.eos     = (s == `NODE_PER_ITER_BANK - 1 && l == nl - 1);
                b.a       = 5'(s * 8 + l);
                b.fv_data = expected_line(stream_addr(it, s, l));
                exp_small_q.push_back(b);
            end
        end
    endtask

    task automatic queue_edge(input logic [5:0] node, input logic [4:0] fv,
                              input logic [1:0] tag);
        fv_bank_pkg::edge_beat_t b;
        int nl;
        nl = (int'(fv) + 1) / 2;
        for (int l = 0; l < nl; l++) begin
            b.valid   = 1'b1;
            b.sos     = (l == 0);
            b.eos     = (l == nl - 1);
            b.pe_tag  = tag;
            b.fv_data = expected_line(node_addr(node, l));
            exp_edge_q.push_back(b);
        end
    endtask

    // reset is looked at from the first falling edge on
    task automatic wait_reset_release();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (reset !== 1'b0 && n < 50);
        if (reset !== 1'b0) begin
            $display("timeout: reset never released");
            err_count++;
        end
    endtask

    // on_edge picks the edge-PE frame count over the small-bank one
    task automatic wait_frames(input bit on_edge, input int target);
        int n;
        n = 0;
        while (((on_edge ? edge_frames : small_frames) < target) && n < 100) begin
            @(negedge clk);
            n++;
        end
        if ((on_edge ? edge_frames : small_frames) < target) begin
            if (on_edge) begin
                $display("timeout: edge-PE frame not finished after %0d cycles", n);
            end else begin
                $display("timeout: small-bank frame not finished after %0d cycles", n);
            end
            err_count++;
        end
    endtask

    task automatic wait_available();
        int n;
        n = 0;
        while (available !== 1'b1 && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (available !== 1'b1) begin
            $display("timeout: controller never returned to idle");
            err_count++;
        end
    endtask

    // unseen beats count as errors and the queues start clean
    task automatic finish_test(input string name, input int err0);
        int missing;
        missing = exp_small_q.size() + exp_edge_q.size();
        if (missing != 0) begin
            $display("test %s: %0d expected beats never arrived", name, missing);
            err_count++;
            exp_small_q.delete();
            exp_edge_q.delete();
        end
        test_count++;
        if (err_count == err0) begin
            $display("test %s: passed", name);
        end else begin
            fail_tests++;
            $display("test %s: failed with %0d errors", name, err_count - err0);
        end
    endtask

    task automatic do_edge_read(input logic [5:0] node, input logic [4:0] fv,
                                input logic [1:0] tag);
        int f0;
        f0 = edge_frames;
        queue_edge(node, fv, tag);
        req.valid   = 1'b1;
        req.rd_wr   = 1'b0;
        req.wr_eos  = 1'b0;
        req.node_id = node;
        req.pe_tag  = tag;
        fv_num      = fv;
        req_cyc     = cyc;
        @(negedge clk);
        // bus changes after acceptance so the latched copy must hold
        req.valid   = 1'b0;
        req.node_id = ~node;
        req.pe_tag  = ~tag;
        wait_frames(1'b1, f0 + 1);
        wait_available();
    endtask

    task automatic check_reset_values();
        int err0;
        err0 = err_count;
        @(negedge clk);
        if (available !== 1'b1) begin
            report_mismatch("available after reset", available, 1);
        end
        if (sram_req.cen !== 1'b1) begin
            report_mismatch("cen after reset", sram_req.cen, 1);
        end
        if (sram_req.wen !== 1'b1) begin
            report_mismatch("wen after reset", sram_req.wen, 1);
        end
        if (small_beat.sos !== 1'b0) begin
            report_mismatch("small sos after reset", small_beat.sos, 0);
        end
        if (small_beat.eos !== 1'b0) begin
            report_mismatch("small eos after reset", small_beat.eos, 0);
        end
        if (edge_beat.valid !== 1'b0) begin
            report_mismatch("edge valid after reset", edge_beat.valid, 0);
        end
        if (edge_beat.sos !== 1'b0) begin
            report_mismatch("edge sos after reset", edge_beat.sos, 0);
        end
        if (edge_beat.eos !== 1'b0) begin
            report_mismatch("edge eos after reset", edge_beat.eos, 0);
        end
        finish_test("reset", err0);
    endtask

    task automatic stream_iteration();
        int err0;
        int f0;
        err0 = err_count;
        f0   = small_frames;
        // 5 features give 3 lines and 12 beats over four slots
        queue_stream(2'd2, 5'd5);
        update_iter  = 4'd1;
        replay_iter  = 2'd2;
        fv_num       = 5'd5;
        stream_begin = 1'b1;
        @(negedge clk);
        stream_begin = 1'b0;
        if (available !== 1'b0) report_mismatch("available after stream start", available, 0);
        wait_frames(1'b0, f0 + 1);
        wait_available();
        // iteration unchanged so only stream_begin can start this one
        f0 = small_frames;
        queue_stream(2'd2, 5'd5);
        stream_begin = 1'b1;
        @(negedge clk);
        stream_begin = 1'b0;
        wait_frames(1'b0, f0 + 1);
        wait_available();
        finish_test("stream", err0);
    endtask

    task automatic iteration_change();
        int err0;
        int f0;
        err0 = err_count;
        f0   = small_frames;
        queue_stream(2'd3, 5'd5);
        // new iteration alone with stream_begin low
        replay_iter = 2'd3;
        @(negedge clk);
        wait_frames(1'b0, f0 + 1);
        wait_available();
        // steady iteration starts no new stream
        f0 = small_frames;
        repeat (12) begin
            @(negedge clk);
            if (sram_req.cen !== 1'b1) begin
                report_mismatch("cen with steady iteration", sram_req.cen, 1);
            end
        end
        if (small_frames != f0) begin
            $display("stream restarted without an iteration change");
            err_count++;
        end
        finish_test("iteration change", err0);
    endtask

    task automatic write_back_node();
        logic [63:0] data [4];
        logic [6:0]  a;
        int          err0;
        err0 = err_count;
        update_iter = 4'd2;
        for (int i = 0; i < 4; i++) begin
            data[i] = {$random(seed), $random(seed)};
            ref_mem[node_addr(6'd13, i)] = data[i];
        end
        @(negedge clk);
        for (int i = 0; i < 4; i++) begin
            req.valid   = 1'b1;
            req.rd_wr   = 1'b1;
            req.wr_eos  = (i == 3);
            // node id only counts on the first beat
            req.node_id = (i == 0) ? 6'd13 : 6'd0;
            req.data    = data[i];
            @(negedge clk);
            if (i < 3 && available !== 1'b0) begin
                report_mismatch("available in write-back", available, 0);
            end
        end
        req = '0;
        wait_available();
        for (int i = 0; i < 4; i++) begin
            a = node_addr(6'd13, i);
            if (mem[a] !== expected_line(a)) begin
                report_mismatch("SRAM line after write-back", mem[a], expected_line(a));
            end
        end
        finish_test("write-back", err0);
    endtask

    task automatic edge_read_node();
        int err0;
        err0 = err_count;
        do_edge_read(6'd13, 5'd8, 2'd2);
        if (edge_sos_cyc - req_cyc != 2) begin
            $display("[FAIL] %0d ns: first edge beat %0d edges after the request, expected 2",
                     $time, edge_sos_cyc - req_cyc);
            err_count++;
        end
        finish_test("edge read", err0);
    endtask

    task automatic random_edge_reads();
        logic [31:0] r;
        int          err0;
        err0 = err_count;
        for (int k = 0; k < 8; k++) begin
            r = $random(seed);
            // fv_num 1..16
            do_edge_read(r[5:0], 5'(r[11:8]) + 5'd1, r[17:16]);
        end
        finish_test("random edge reads", err0);
    endtask

    initial begin
        seed         = 4744;
        replay_iter  = '0;
        update_iter  = '0;
        stream_begin = 1'b0;
        fv_num       = 5'd1;
        req          = '0;
        sram_rdata   = '0;
        // random preload and an identical shadow
        for (int i = 0; i < 128; i++) begin
            mem[i]     = {$random(seed), $random(seed)};
            ref_mem[i] = mem[i];
        end
        wait_reset_release();
        check_reset_values();
        stream_iteration();
        iteration_change();
        write_back_node();
        edge_read_node();
        random_edge_reads();
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 test_count, test_count - fail_tests, fail_tests, err_count);
        if (err_count == 0 && fail_tests == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
